// File: verilog/fetchPkg.sv
`default_nettype none

package fetchPkg;

    typedef logic [31:0] wordT;  // raw instruction word
    typedef logic [31:0] addrT;  // byte address, the pc
    typedef logic [31:0] immT;   // sign-extended immediate

    localparam int memWords = 256;                   // rom size in words
    localparam int memIdxBits = $clog2(memWords);    // word index width
    localparam int queueDepth = 4;                   // fetch fifo entries
    localparam int queuePtrBits = $clog2(queueDepth);
    localparam addrT resetPc = 32'h0000_0000;        // first fetch address

    typedef logic [queuePtrBits-1:0] queuePtrT;      // fifo read/write pointer

    // base opcodes, instr[6:0]
    localparam logic [6:0] opAluImm = 7'b0010011;
    localparam logic [6:0] opAluReg = 7'b0110011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;

    typedef enum logic [2:0] {
        kindAluImm = 3'd0,  // addi, slli ...
        kindAluReg = 3'd1,  // add, sub ...
        kindLoad   = 3'd2,
        kindStore  = 3'd3,
        kindBranch = 3'd4,  // conditional, fetch treats as not taken
        kindJal    = 3'd5,  // resolved in predecode
        kindJalr   = 3'd6,
        kindOther  = 3'd7   // anything unrecognized
    } instrKindT;

    typedef enum logic [1:0] {
        phaseIdle        = 2'd0,  // req low, may start
        phaseWaitAck     = 2'd1,  // req high, waiting for ack
        phaseWaitRelease = 2'd2   // req dropped, waiting for ack low
    } phaseT;

endpackage

`default_nettype wire

// File: verilog/fetchLinkIf.sv
`default_nettype none

// four-phase req/ack link carrying one fetched instruction
interface fetchLinkIf;
    import fetchPkg::*;

    logic req;    // sender has stable data
    logic ack;    // receiver captured data
    addrT pc;     // address the word came from
    wordT instr;  // fetched word
    logic epoch;  // fetch epoch, flips on each redirect

    modport sender (
        output req, pc, instr, epoch,
        input  ack
    );

    modport receiver (
        input  req, pc, instr, epoch,
        output ack
    );

endinterface

`default_nettype wire

// File: verilog/instrMem.sv
`default_nettype none

module instrMem (
    input  fetchPkg::addrT addr,
    output fetchPkg::wordT data
);
    import fetchPkg::*;

    wordT        romWords [memWords];  // program store, one entry per word
    logic [29:0] wordIdx;              // byte address with low bits dropped

    initial begin
        foreach (romWords[i]) begin
            romWords[i] = '0;  // unlisted words read as zero
        end
        $readmemh("program.hex", romWords);
    end

    assign wordIdx = addr[31:2];  // word aligned, bits 1:0 ignored

    always_comb begin
        if (wordIdx < memWords) begin
            data = romWords[wordIdx[memIdxBits-1:0]];
        end else begin
            data = '0;  // past end of rom
        end
    end

endmodule

`default_nettype wire

// File: verilog/pcGen.sv
`default_nettype none

module pcGen (
    input  logic           clk,
    input  logic           rstN,
    fetchLinkIf.sender     link,
    output fetchPkg::addrT memAddr,
    input  fetchPkg::wordT memData,
    input  logic           redirectValid,
    input  fetchPkg::addrT redirectPc
);
    import fetchPkg::*;

    addrT  pc;            // next address to fetch
    logic  epoch;         // current fetch epoch
    phaseT phase;         // sender side of the link
    logic  redirPending;  // redirect seen while busy
    addrT  redirTarget;   // its target
    logic  redirNow;      // a redirect is to be applied
    addrT  redirAddr;     // target of that redirect

    assign memAddr = pc;  // rom read is combinational

    // a fresh pulse wins over the latched one
    assign redirNow  = redirectValid | redirPending;
    assign redirAddr = redirectValid ? redirectPc : redirTarget;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            redirPending <= 1'b0;
        end else if (phase == phaseIdle) begin
            redirPending <= 1'b0;  // applied this cycle
        end else if (redirectValid) begin
            redirPending <= 1'b1;  // hold until sender idle
        end
    end

    always_ff @(posedge clk) begin
        if (redirectValid) begin
            redirTarget <= redirectPc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc       <= resetPc;
            epoch    <= 1'b0;
            phase    <= phaseIdle;
            link.req <= 1'b0;
        end else begin
            case (phase)
                phaseIdle: begin
                    if (redirNow) begin
                        pc    <= redirAddr;  // jump, fetch from target next cycle
                        epoch <= ~epoch;     // older entries become stale
                    end else begin
                        link.req   <= 1'b1;  // data set up on the same edge
                        link.pc    <= pc;
                        link.instr <= memData;
                        link.epoch <= epoch;
                        phase      <= phaseWaitAck;
                    end
                end
                phaseWaitAck: begin
                    if (link.ack) begin
                        link.req <= 1'b0;
                        pc       <= pc + 32'd4;  // sequential, branches not taken
                        phase    <= phaseWaitRelease;
                    end
                end
                phaseWaitRelease: begin
                    if (!link.ack) begin
                        phase <= phaseIdle;  // link free again
                    end
                end
                default: phase <= phaseIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetchQueue.sv
`default_nettype none

module fetchQueue (
    input  logic         clk,
    input  logic         rstN,
    fetchLinkIf.receiver inLink,
    fetchLinkIf.sender   outLink
);
    import fetchPkg::*;

    addrT pcStore    [queueDepth];  // entry pc
    wordT instrStore [queueDepth];  // entry word
    logic epochStore [queueDepth];  // entry epoch

    queuePtrT              wrPtr;    // next free slot
    queuePtrT              rdPtr;    // head entry
    logic [queuePtrBits:0] count;    // 0 .. queueDepth
    logic                  full;
    logic                  empty;
    logic                  push;     // accept incoming entry
    logic                  pop;      // head handed over
    phaseT                 txPhase;  // sender side toward predecode

    function automatic queuePtrT nextPtr(input queuePtrT ptr);
        return (ptr == queuePtrT'(queueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == queueDepth);
    assign empty = (count == '0);
    assign push  = inLink.req && !inLink.ack && !full;  // ack held off while full
    assign pop   = (txPhase == phaseWaitAck) && outLink.ack;

    // receive side, ack follows req by one cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            inLink.ack <= 1'b0;
        end else if (push) begin
            inLink.ack <= 1'b1;
        end else if (inLink.ack && !inLink.req) begin
            inLink.ack <= 1'b0;  // sender released
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pcStore[wrPtr]    <= inLink.pc;
            instrStore[wrPtr] <= inLink.instr;
            epochStore[wrPtr] <= inLink.epoch;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) wrPtr <= nextPtr(wrPtr);
            if (pop)  rdPtr <= nextPtr(rdPtr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none or both
            endcase
        end
    end

    // send side, head entry copied into link registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            txPhase     <= phaseIdle;
            outLink.req <= 1'b0;
        end else begin
            case (txPhase)
                phaseIdle: begin
                    if (!empty) begin
                        outLink.req   <= 1'b1;
                        outLink.pc    <= pcStore[rdPtr];
                        outLink.instr <= instrStore[rdPtr];
                        outLink.epoch <= epochStore[rdPtr];
                        txPhase       <= phaseWaitAck;
                    end
                end
                phaseWaitAck: begin
                    if (outLink.ack) begin
                        outLink.req <= 1'b0;  // pop happens on this edge
                        txPhase     <= phaseWaitRelease;
                    end
                end
                phaseWaitRelease: begin
                    if (!outLink.ack) txPhase <= phaseIdle;
                end
                default: txPhase <= phaseIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/instrDecode.sv
`default_nettype none

module instrDecode (
    input  logic                clk,
    input  logic                rstN,
    fetchLinkIf.receiver        inLink,
    output logic                redirectValid,
    output fetchPkg::addrT      redirectPc,
    output logic                outReq,
    input  logic                outAck,
    output fetchPkg::addrT      outPc,
    output fetchPkg::wordT      outInstr,
    output fetchPkg::instrKindT outKind,
    output fetchPkg::immT       outImm
);
    import fetchPkg::*;

    logic      curEpoch;  // epoch expected from fetch
    phaseT     outPhase;  // output handshake state
    logic      take;      // accept entry this cycle
    logic      isCurrent; // entry belongs to current epoch
    instrKindT kind;      // decoded class of incoming word
    immT       imm;       // decoded immediate of incoming word
    wordT      ins;

    assign ins       = inLink.instr;
    assign isCurrent = (inLink.epoch == curEpoch);
    // only one entry in flight outward
    assign take      = inLink.req && !inLink.ack && (outPhase == phaseIdle);

    always_comb begin
        case (ins[6:0])
            opAluImm: kind = kindAluImm;
            opAluReg: kind = kindAluReg;
            opLoad:   kind = kindLoad;
            opStore:  kind = kindStore;
            opBranch: kind = kindBranch;
            opJal:    kind = kindJal;
            opJalr:   kind = kindJalr;
            default:  kind = kindOther;
        endcase
    end

    always_comb begin
        case (kind)
            kindAluImm, kindLoad, kindJalr:  // I format
                imm = {{20{ins[31]}}, ins[31:20]};
            kindStore:                       // S format
                imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            kindBranch:                      // B format, bit 0 always zero
                imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            kindJal:                         // J format
                imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default:
                imm = '0;                    // R type and unknown
        endcase
    end

    // input side, ack one cycle after req, stale entries just acked
    always_ff @(posedge clk) begin
        if (!rstN) begin
            inLink.ack    <= 1'b0;
            curEpoch      <= 1'b0;
            redirectValid <= 1'b0;
        end else begin
            redirectValid <= 1'b0;  // single cycle pulse
            if (take) begin
                inLink.ack <= 1'b1;
                if (isCurrent && kind == kindJal) begin
                    redirectValid <= 1'b1;
                    curEpoch      <= ~curEpoch;  // drop what is already queued
                end
            end else if (inLink.ack && !inLink.req) begin
                inLink.ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && isCurrent) begin
            redirectPc <= inLink.pc + imm;  // only meaningful for jal
            outPc      <= inLink.pc;
            outInstr   <= ins;
            outKind    <= kind;
            outImm     <= imm;
        end
    end

    // output side
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outPhase <= phaseIdle;
            outReq   <= 1'b0;
        end else begin
            case (outPhase)
                phaseIdle: begin
                    if (take && isCurrent) begin
                        outReq   <= 1'b1;  // outputs loaded on same edge
                        outPhase <= phaseWaitAck;
                    end
                end
                phaseWaitAck: begin
                    if (outAck) begin
                        outReq   <= 1'b0;
                        outPhase <= phaseWaitRelease;
                    end
                end
                phaseWaitRelease: begin
                    if (!outAck) outPhase <= phaseIdle;
                end
                default: outPhase <= phaseIdle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetchTop.sv
`default_nettype none

module fetchTop (
    input  logic                clk,
    input  logic                rstN,
    output logic                outReq,
    input  logic                outAck,
    output fetchPkg::addrT      outPc,
    output fetchPkg::wordT      outInstr,
    output fetchPkg::instrKindT outKind,
    output fetchPkg::immT       outImm
);
    import fetchPkg::*;

    addrT memAddr;        // pc into rom
    wordT memData;        // rom word back to pc generator
    logic redirectValid;  // jal taken in predecode
    addrT redirectPc;     // jal target

    fetchLinkIf fetchLink ();  // pcGen to queue
    fetchLinkIf issueLink ();  // queue to predecode

    instrMem uInstrMem (
        .addr (memAddr),
        .data (memData)
    );

    pcGen uPcGen (
        .clk           (clk),
        .rstN          (rstN),
        .link          (fetchLink.sender),
        .memAddr       (memAddr),
        .memData       (memData),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

    fetchQueue uFetchQueue (
        .clk     (clk),
        .rstN    (rstN),
        .inLink  (fetchLink.receiver),
        .outLink (issueLink.sender)
    );

    instrDecode uInstrDecode (
        .clk           (clk),
        .rstN          (rstN),
        .inLink        (issueLink.receiver),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .outReq        (outReq),
        .outAck        (outAck),
        .outPc         (outPc),
        .outInstr      (outInstr),
        .outKind       (outKind),
        .outImm        (outImm)
    );

endmodule

`default_nettype wire

// File: verification/fetchTop_chk.sv
`default_nettype none

module fetchTopChk (
    input logic           clk,
    input logic           rstN,
    input logic           outReq,
    input logic           outAck,
    input fetchPkg::addrT outPc,
    input fetchPkg::wordT outInstr,
    input logic           redirectValid
);

    // output data frozen until the environment acks
    holdData: assert property (@(posedge clk) disable iff (!rstN)
        outReq && !outAck |=> $stable(outPc) && $stable(outInstr))
        else $error("outPc or outInstr changed while outReq waited for outAck");

    // new request only once the previous ack is gone
    noEarlyReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(outReq) |-> !outAck)
        else $error("outReq rose while outAck was still high");

    // jal redirect is a single cycle pulse
    redirPulse: assert property (@(posedge clk) disable iff (!rstN)
        redirectValid |=> !redirectValid)
        else $error("redirectValid held for more than one cycle");

endmodule

bind fetchTop fetchTopChk uChk (
    .clk           (clk),
    .rstN          (rstN),
    .outReq        (outReq),
    .outAck        (outAck),
    .outPc         (outPc),
    .outInstr      (outInstr),
    .redirectValid (redirectValid)
);

`default_nettype wire

// File: verification/fetchTb.sv
`default_nettype none

module fetchTb;
    import fetchPkg::*;

    localparam int numXfers      = 40;                 // transfers checked
    localparam int timeoutCycles = numXfers * 12 + 5;  // worst spacing plus reset
    localparam int numTests      = 5;
    localparam int tSeq          = 0;
    localparam int tClass        = 1;
    localparam int tJump         = 2;
    localparam int tBranch       = 3;
    localparam int tBack         = 4;

    logic      clk;
    logic      rstN;
    logic      outReq;
    logic      outAck;
    addrT      outPc;
    wordT      outInstr;
    instrKindT outKind;
    immT       outImm;

    wordT   progWords [memWords];  // own copy of the program
    integer seed = 32'hc4b87083;
    int     waitLeft;              // ack delay still to run
    logic   armed;                 // delay drawn for current req
    int     cycleCount = 0;
    int     xferCount = 0;
    logic   reqSeen = 1'b0;        // outReq seen on previous edge
    addrT   expPc = resetPc;       // reference pc of next transfer
    logic   afterJal = 1'b0;
    logic   afterBranch = 1'b0;
    addrT   branchPc;
    int     checkCount [numTests] = '{default: 0};
    int     errCount [numTests] = '{default: 0};
    string  testNames [numTests] = '{"sequentialFetch", "classifyImm", "jumpRedirect",
                                     "branchNotTaken", "backPressure"};

    fetchTop UUT (
        .clk      (clk),
        .rstN     (rstN),
        .outReq   (outReq),
        .outAck   (outAck),
        .outPc    (outPc),
        .outInstr (outInstr),
        .outKind  (outKind),
        .outImm   (outImm)
    );

    always #20 clk = ~clk;

    // expected word, class and immediate at a pc taken from the ISA encoding
    function automatic void refDecode(input addrT pc, output wordT word,
                                      output instrKindT kind, output immT imm);
        word = progWords[pc[memIdxBits+1:2]];
        case (word[6:0])
            opAluImm: kind = kindAluImm;
            opAluReg: kind = kindAluReg;
            opLoad:   kind = kindLoad;
            opStore:  kind = kindStore;
            opBranch: kind = kindBranch;
            opJal:    kind = kindJal;
            opJalr:   kind = kindJalr;
            default:  kind = kindOther;
        endcase
        case (kind)
            kindAluImm, kindLoad, kindJalr: imm = $signed(word) >>> 20;
            kindStore:  imm = $signed({word[31:25], word[11:7], 20'h0}) >>> 20;
            kindBranch: imm = $signed({word[31], word[7], word[30:25], word[11:8], 20'h0}) >>> 19;
            kindJal:    imm = $signed({word[31], word[19:12], word[20], word[30:21], 12'h0}) >>> 11;
            default:    imm = '0;  // no immediate
        endcase
    endfunction

    task automatic compareField(input int t, input string what,
                                input logic [31:0] expVal, input logic [31:0] actVal);
        checkCount[t]++;
        assert (actVal === expVal) else begin
            $display("FAIL %s %s expected %08h actual %08h", testNames[t], what, expVal, actVal);
            errCount[t]++;
        end
    endtask

    task automatic reportTest(input int t);
        $display("%-15s %3d checks %2d errors", testNames[t], checkCount[t], errCount[t]);
    endtask

    // environment side of the output handshake with a random ack delay
    always @(posedge clk) begin
        if (!rstN) begin
            outAck <= 1'b0;
            armed  <= 1'b0;
        end else if (outAck) begin
            if (!outReq) outAck <= 1'b0;  // req gone so release
        end else if (outReq) begin
            if (!armed) begin
                waitLeft <= $random(seed) & 3;  // 0..3 extra cycles
                armed    <= 1'b1;
            end else if (waitLeft > 0) begin
                waitLeft <= waitLeft - 1;
            end else begin
                outAck <= 1'b1;
                armed  <= 1'b0;
            end
        end
    end

    // one comparison per rising outReq
    always @(posedge clk) begin : compareXfer
        wordT      expWord;
        instrKindT expKind;
        immT       expImm;
        if (rstN && outReq && !reqSeen && xferCount < numXfers) begin
            refDecode(expPc, expWord, expKind, expImm);
            if (xferCount < 9) begin  // first pass through the loop
                compareField(tSeq, "pc", expPc, outPc);
                compareField(tSeq, "word", expWord, outInstr);
            end
            compareField(tBack, "pc", expPc, outPc);
            compareField(tBack, "word", expWord, outInstr);
            compareField(tClass, "kind", 32'(expKind), 32'(outKind));
            compareField(tClass, "imm", expImm, outImm);
            if (expKind == kindJal) begin
                compareField(tClass, "jal offset", 32'hffff_ffe0, outImm);  // minus 32
            end
            if (afterJal) begin
                compareField(tJump, "pc after jal", expPc, outPc);
            end
            checkCount[tJump]++;
            assert (outPc != 32'd36 && outPc != 32'd40) else begin
                $display("jumpRedirect: wrong-path entry from pc %0d was delivered", outPc);
                errCount[tJump]++;
            end
            if (expKind == kindBranch) begin
                compareField(tBranch, "branch kind", 32'(kindBranch), 32'(outKind));
                compareField(tBranch, "branch imm", expImm, outImm);
            end
            if (afterBranch) begin
                compareField(tBranch, "pc after branch", branchPc + 32'd4, outPc);
            end
            afterJal    = (expKind == kindJal);
            afterBranch = (expKind == kindBranch);
            branchPc    = expPc;
            expPc       = (expKind == kindJal) ? expPc + expImm : expPc + 32'd4;
            xferCount++;  // main flow waits on this count
        end
        reqSeen = rstN && outReq;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            $display("timeout: %0d of %0d transfers seen after %0d cycles",
                     xferCount, numXfers, cycleCount);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int totChecks;
        int totErrs;
        clk    = 1'b0;
        rstN   = 1'b0;
        outAck = 1'b0;
        $readmemh("program.hex", progWords);
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        wait (xferCount >= 9);
        reportTest(tSeq);  // first loop pass complete
        wait (xferCount == numXfers);
        reportTest(tClass);
        reportTest(tJump);
        reportTest(tBranch);
        reportTest(tBack);
        totChecks = 0;
        totErrs   = 0;
        for (int i = 0; i < numTests; i++) begin
            totChecks += checkCount[i];
            totErrs   += errCount[i];
        end
        $display("%0d transfers, %0d checks, %0d errors", xferCount, totChecks, totErrs);
        if (totErrs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
verilog/fetchPkg.sv
verilog/fetchLinkIf.sv
verilog/instrMem.sv
verilog/pcGen.sv
verilog/fetchQueue.sv
verilog/instrDecode.sv
verilog/fetchTop.sv
verification/fetchTop_chk.sv
verification/fetchTb.sv

// File: program.hex
// one 32-bit instruction word per line in hex, word 0 first (pc = 4 * line index)
00500093  // pc 0   addi x1, x0, 5
FE114CE3  // pc 4   blt x2, x1, -8 (fetch treats as not taken)
002081B3  // pc 8   add x3, x1, x2
FE312E23  // pc 12  sw x3, -4(x2)
00802203  // pc 16  lw x4, 8(x0)
FFF08093  // pc 20  addi x1, x1, -1
00C28067  // pc 24  jalr x0, 12(x5), not resolved in fetch
12345337  // pc 28  lui x6, 0x12345, decodes as other
FE1FF06F  // pc 32  jal x0, -32 back to pc 0
00100393  // pc 36  addi x7, x0, 1, wrong path
00200413  // pc 40  addi x8, x0, 2, wrong path
